// ==== bridge_cmd_pkg.sv ====
/*
 * shared definitions of the bridge command handler:
 * address map, command, result and magic codes, bus and status structs
 */
package bridge_cmd_pkg;

    localparam int data_w   = 32;
    localparam int table_aw = 10;   // 1024-word data table

    // 2-bit region field decoded from the bridge address
    localparam logic [1:0] region_none  = 2'd0;
    localparam logic [1:0] region_host  = 2'd1;  // 0xF8xx00xx
    localparam logic [1:0] region_table = 2'd2;  // 0xF8xx2xxx

    // byte offsets inside the host region
    localparam logic [7:0] off_status    = 8'h00;
    localparam logic [7:0] off_param_ptr = 8'h04;
    localparam logic [7:0] off_resp_ptr  = 8'h08;
    localparam logic [7:0] off_param0    = 8'h20;
    localparam logic [7:0] off_param1    = 8'h24;
    localparam logic [7:0] off_param2    = 8'h28;
    localparam logic [7:0] off_param3    = 8'h2C;

    localparam logic [data_w-1:0] param_ptr_value = 32'h20;
    localparam logic [data_w-1:0] resp_ptr_value  = 32'h40;

    // upper halfword of the status word
    localparam logic [15:0] magic_cmd  = 16'h434D;  // "CM"
    localparam logic [15:0] magic_busy = 16'h4255;  // "BU"
    localparam logic [15:0] magic_ok   = 16'h4F4B;  // "OK"

    localparam logic [15:0] cmd_status           = 16'h0000;
    localparam logic [15:0] cmd_reset_enter      = 16'h0010;
    localparam logic [15:0] cmd_reset_exit       = 16'h0011;
    localparam logic [15:0] cmd_slot_read        = 16'h0080;
    localparam logic [15:0] cmd_slot_update      = 16'h008A;
    localparam logic [15:0] cmd_slot_allcomplete = 16'h008F;
    localparam logic [15:0] cmd_rtc              = 16'h0090;
    localparam logic [15:0] cmd_menu             = 16'h00B0;
    localparam logic [15:0] cmd_docked           = 16'h00B2;

    localparam logic [15:0] result_unknown = 16'hFFFF;

    // one registered bridge access
    typedef struct packed {
        logic                wr;
        logic                rd;
        logic [1:0]          region;
        logic [7:0]          offset;
        logic [table_aw-1:0] taddr;   // table word address
        logic [data_w-1:0]   wdata;   // already byte-swapped
    } bus_req_t;

    typedef struct packed {
        logic [data_w-1:0] param0;
        logic [data_w-1:0] param1;
        logic [data_w-1:0] param2;
    } host_params_t;

    typedef struct packed {
        logic              wr;
        logic [data_w-1:0] word;
    } host_status_t;

endpackage

// ==== bridge_port.sv ====
/*
 * bridge side front end: endian flag synchronizer,
 * byte swap of write and read data, address decode into a registered request
 */
module bridge_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                endian_little,
    input  logic [31:0]                         addr,
    input  logic                                rd,
    input  logic                                wr,
    input  logic [31:0]                         wr_data,
    input  logic [31:0]                         rd_word,
    output bridge_cmd_pkg::bus_req_t            req,
    output logic [31:0]                         rd_data
);

    logic [2:0] endian_sync;    // three flop synchronizer
    logic       little;
    logic [1:0] region;

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign little = endian_sync[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            endian_sync <= '0;
        end else begin
            endian_sync <= {endian_sync[1:0], endian_little};
        end
    end

    // 0xF8xx00xx host registers, 0xF8xx2xxx data table
    always_comb begin
        region = bridge_cmd_pkg::region_none;
        if (addr[31:24] == 8'hF8) begin
            if (addr[15:8] == 8'h00)
                region = bridge_cmd_pkg::region_host;
            else if (addr[15:12] == 4'h2)
                region = bridge_cmd_pkg::region_table;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req.wr <= 1'b0;
            req.rd <= 1'b0;
        end else begin
            req.wr <= wr;
            req.rd <= rd;
        end
    end

    always_ff @(posedge clk) begin
        req.region <= region;
        req.offset <= addr[7:0];
        req.taddr  <= addr[bridge_cmd_pkg::table_aw+1:2];  // word address
        req.wdata  <= little ? byte_swap(wr_data) : wr_data;
    end

    assign rd_data = little ? byte_swap(rd_word) : rd_word;

endmodule

// ==== host_regfile.sv ====
/*
 * host register block: command/status word, parameter registers,
 * command semaphore detection and the two-stage read data mux
 */
module host_regfile (
    input  logic                            clk,
    input  logic                            rst,
    input  bridge_cmd_pkg::bus_req_t        req,
    input  logic [31:0]                     table_q,
    input  bridge_cmd_pkg::host_status_t    status_upd,
    output bridge_cmd_pkg::host_params_t    params,
    output logic                            cmd_start,
    output logic [15:0]                     cmd_code,
    output logic [31:0]                     rd_word
);

    logic [31:0] status_word;
    logic [31:0] param3;
    logic [31:0] host_q;        // host register read, first stage
    logic [1:0]  region_dly;
    logic        rd_dly;
    logic        host_wr;

    assign host_wr = req.wr && (req.region == bridge_cmd_pkg::region_host);

    // status word, executor update wins over a bridge write
    always_ff @(posedge clk) begin
        if (rst) begin
            status_word <= '0;
            cmd_start   <= 1'b0;
        end else begin
            cmd_start <= host_wr && (req.offset == bridge_cmd_pkg::off_status) &&
                         (req.wdata[31:16] == bridge_cmd_pkg::magic_cmd);
            if (status_upd.wr)
                status_word <= status_upd.word;
            else if (host_wr && req.offset == bridge_cmd_pkg::off_status)
                status_word <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        cmd_code <= req.wdata[15:0];    // only looked at with cmd_start
        if (host_wr) begin
            case (req.offset)
                bridge_cmd_pkg::off_param0: params.param0 <= req.wdata;
                bridge_cmd_pkg::off_param1: params.param1 <= req.wdata;
                bridge_cmd_pkg::off_param2: params.param2 <= req.wdata;
                bridge_cmd_pkg::off_param3: param3 <= req.wdata;
                default: ;
            endcase
        end
    end

    // first stage runs alongside the table read
    always_ff @(posedge clk) begin
        region_dly <= req.region;
        case (req.offset)
            bridge_cmd_pkg::off_status:    host_q <= status_word;
            bridge_cmd_pkg::off_param_ptr: host_q <= bridge_cmd_pkg::param_ptr_value;
            bridge_cmd_pkg::off_resp_ptr:  host_q <= bridge_cmd_pkg::resp_ptr_value;
            bridge_cmd_pkg::off_param0:    host_q <= params.param0;
            bridge_cmd_pkg::off_param1:    host_q <= params.param1;
            bridge_cmd_pkg::off_param2:    host_q <= params.param2;
            bridge_cmd_pkg::off_param3:    host_q <= param3;
            default:                       host_q <= '0;   // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            rd_dly <= 1'b0;
        else
            rd_dly <= req.rd;
    end

    // second stage, held until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_word <= '0;
        end else if (rd_dly) begin
            case (region_dly)
                bridge_cmd_pkg::region_host:  rd_word <= host_q;
                bridge_cmd_pkg::region_table: rd_word <= table_q;
                default:                      rd_word <= '0;
            endcase
        end
    end

endmodule

// ==== host_cmd_exec.sv ====
/*
 * host command executor: idle/parse/done FSM driving the
 * core control outputs and the busy and result words
 */
module host_cmd_exec (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_start,
    input  logic [15:0]                     cmd_code,
    input  bridge_cmd_pkg::host_params_t    params,
    input  logic                            status_boot_done,
    input  logic                            status_setup_done,
    input  logic                            status_running,
    input  logic                            dataslot_requestread_ack,
    input  logic                            dataslot_requestread_ok,
    output bridge_cmd_pkg::host_status_t    status_upd,
    output logic                            reset_n,
    output logic                            dataslot_requestread,
    output logic [15:0]                     dataslot_requestread_id,
    output logic                            dataslot_update,
    output logic [15:0]                     dataslot_update_id,
    output logic [31:0]                     dataslot_update_size,
    output logic                            dataslot_allcomplete,
    output logic                            rtc_valid,
    output logic [31:0]                     rtc_epoch_seconds,
    output logic [31:0]                     rtc_date_bcd,
    output logic [31:0]                     rtc_time_bcd,
    output logic                            osnotify_inmenu,
    output logic                            osnotify_docked
);

    typedef enum logic [1:0] {st_idle, st_parse, st_done} state_t;

    state_t      state;
    logic [15:0] cmd;           // latched so a later bridge write cannot clobber it
    logic [15:0] result;

    always_ff @(posedge clk) begin
        if (rst) begin
            state                <= st_idle;
            reset_n              <= 1'b0;
            dataslot_requestread <= 1'b0;
            dataslot_update      <= 1'b0;
            dataslot_allcomplete <= 1'b0;
            rtc_valid            <= 1'b0;
            osnotify_inmenu      <= 1'b0;
            osnotify_docked      <= 1'b0;
        end else begin
            case (state)
                st_idle: if (cmd_start) state <= st_parse;
                st_parse: begin
                    state <= st_done;
                    case (cmd)
                        bridge_cmd_pkg::cmd_reset_enter: reset_n <= 1'b0;
                        bridge_cmd_pkg::cmd_reset_exit:  reset_n <= 1'b1;
                        bridge_cmd_pkg::cmd_slot_read: begin
                            dataslot_allcomplete <= 1'b0;
                            dataslot_requestread <= 1'b1;
                            if (!dataslot_requestread_ack)
                                state <= st_parse;  // wait for the core
                        end
                        bridge_cmd_pkg::cmd_slot_update:      dataslot_update <= 1'b1;
                        bridge_cmd_pkg::cmd_slot_allcomplete: dataslot_allcomplete <= 1'b1;
                        bridge_cmd_pkg::cmd_rtc:    rtc_valid <= 1'b1;
                        bridge_cmd_pkg::cmd_menu:   osnotify_inmenu <= params.param0[0];
                        bridge_cmd_pkg::cmd_docked: osnotify_docked <= params.param0[0];
                        default: ;
                    endcase
                end
                default: begin
                    // pulses end as the FSM returns to idle
                    dataslot_requestread <= 1'b0;
                    dataslot_update      <= 1'b0;
                    state                <= st_idle;
                end
            endcase
        end
    end

    // command latch, parameter copies and result code
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_start)
            cmd <= cmd_code;
        if (state == st_parse) begin
            result <= '0;
            case (cmd)
                bridge_cmd_pkg::cmd_status: begin
                    if (!status_boot_done)
                        result <= 16'd1;    // booting
                    else if (status_setup_done)
                        result <= 16'd3;    // idle
                    else if (status_running)
                        result <= 16'd4;    // running
                    else
                        result <= 16'd2;    // setup
                end
                bridge_cmd_pkg::cmd_slot_read: begin
                    dataslot_requestread_id <= params.param0[15:0];
                    if (!dataslot_requestread_ok)
                        result <= 16'd2;
                end
                bridge_cmd_pkg::cmd_slot_update: begin
                    dataslot_update_id   <= params.param0[15:0];
                    dataslot_update_size <= params.param1;
                end
                bridge_cmd_pkg::cmd_rtc: begin
                    rtc_epoch_seconds <= params.param0;
                    rtc_date_bcd      <= params.param1;
                    rtc_time_bcd      <= params.param2;
                end
                bridge_cmd_pkg::cmd_reset_enter, bridge_cmd_pkg::cmd_reset_exit,
                bridge_cmd_pkg::cmd_slot_allcomplete, bridge_cmd_pkg::cmd_menu,
                bridge_cmd_pkg::cmd_docked: ;
                default: result <= bridge_cmd_pkg::result_unknown;
            endcase
        end
    end

    // busy word while parsing, result word in done
    always_comb begin
        status_upd = '0;
        case (state)
            st_parse: status_upd = '{wr: 1'b1, word: {bridge_cmd_pkg::magic_busy, cmd}};
            st_done:  status_upd = '{wr: 1'b1, word: {bridge_cmd_pkg::magic_ok, result}};
            default: ;
        endcase
    end

endmodule

// ==== datatable_ram.sv ====
/*
 * true dual-port data table, read-before-write, one cycle read latency
 */
module datatable_ram (
    input  logic                                clk,
    input  logic [bridge_cmd_pkg::table_aw-1:0] a_addr,
    input  logic                                a_wren,
    input  logic [31:0]                         a_data,
    output logic [31:0]                         a_q,
    input  logic [bridge_cmd_pkg::table_aw-1:0] b_addr,
    input  logic                                b_wren,
    input  logic [31:0]                         b_data,
    output logic [31:0]                         b_q
);

    logic [31:0] mem [2**bridge_cmd_pkg::table_aw];

    // core side
    always @(posedge clk) begin
        if (a_wren)
            mem[a_addr] <= a_data;
        a_q <= mem[a_addr];     // old data on a write
    end

    // bridge side
    always @(posedge clk) begin
        if (b_wren)
            mem[b_addr] <= b_data;
        b_q <= mem[b_addr];
    end

endmodule

// ==== core_bridge_cmd.sv ====
/*
 * bridge command handler top: bridge port, host registers,
 * command executor and data table
 */
module core_bridge_cmd (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                bridge_endian_little,
    input  logic [31:0]                         bridge_addr,
    input  logic                                bridge_rd,
    output logic [31:0]                         bridge_rd_data,
    input  logic                                bridge_wr,
    input  logic [31:0]                         bridge_wr_data,
    input  logic                                status_boot_done,
    input  logic                                status_setup_done,
    input  logic                                status_running,
    output logic                                reset_n,
    output logic                                dataslot_requestread,
    output logic [15:0]                         dataslot_requestread_id,
    input  logic                                dataslot_requestread_ack,
    input  logic                                dataslot_requestread_ok,
    output logic                                dataslot_update,
    output logic [15:0]                         dataslot_update_id,
    output logic [31:0]                         dataslot_update_size,
    output logic                                dataslot_allcomplete,
    output logic                                rtc_valid,
    output logic [31:0]                         rtc_epoch_seconds,
    output logic [31:0]                         rtc_date_bcd,
    output logic [31:0]                         rtc_time_bcd,
    output logic                                osnotify_inmenu,
    output logic                                osnotify_docked,
    input  logic [bridge_cmd_pkg::table_aw-1:0] datatable_addr,
    input  logic                                datatable_wren,
    input  logic [31:0]                         datatable_data,
    output logic [31:0]                         datatable_q
);

    bridge_cmd_pkg::bus_req_t     req;
    bridge_cmd_pkg::host_params_t params;
    bridge_cmd_pkg::host_status_t status_upd;
    logic [31:0]                  rd_word;
    logic [31:0]                  table_q;
    logic                         cmd_start;
    logic [15:0]                  cmd_code;

    bridge_port i_port (
        .clk, .rst,
        .endian_little (bridge_endian_little),
        .addr (bridge_addr), .rd (bridge_rd), .wr (bridge_wr),
        .wr_data (bridge_wr_data), .rd_word, .req, .rd_data (bridge_rd_data)
    );

    host_regfile i_regs (
        .clk, .rst, .req, .table_q, .status_upd, .params, .cmd_start, .cmd_code, .rd_word
    );

    host_cmd_exec i_exec (
        .clk, .rst, .cmd_start, .cmd_code, .params,
        .status_boot_done, .status_setup_done, .status_running,
        .dataslot_requestread_ack, .dataslot_requestread_ok, .status_upd, .reset_n,
        .dataslot_requestread, .dataslot_requestread_id,
        .dataslot_update, .dataslot_update_id, .dataslot_update_size,
        .dataslot_allcomplete, .rtc_valid, .rtc_epoch_seconds, .rtc_date_bcd,
        .rtc_time_bcd, .osnotify_inmenu, .osnotify_docked
    );

    datatable_ram i_table (
        .clk,
        .a_addr (datatable_addr), .a_wren (datatable_wren),
        .a_data (datatable_data), .a_q (datatable_q),
        .b_addr (req.taddr),
        .b_wren (req.wr && req.region == bridge_cmd_pkg::region_table),
        .b_data (req.wdata), .b_q (table_q)
    );

endmodule

// ==== core_bridge_cmd_checker.sv ====
/*
 * concurrent assertions on the command executor outputs, bound to host_cmd_exec
 */
module core_bridge_cmd_checker (
    input logic clk,
    input logic rst,
    input logic reset_n,
    input logic dataslot_requestread,
    input logic dataslot_requestread_ack,
    input logic dataslot_update
);

    // update is a single cycle strobe
    assert property (@(posedge clk) disable iff (rst)
        $rose(dataslot_update) |=> !dataslot_update)
        else $error("dataslot_update held longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        $fell(dataslot_requestread) |-> $past(dataslot_requestread_ack))
        else $error("dataslot_requestread dropped without ack");

    assert property (@(posedge clk) rst |=> !reset_n)
        else $error("reset_n high during rst");   // core held in reset

endmodule

bind host_cmd_exec core_bridge_cmd_checker i_chk (
    .clk,
    .rst,
    .reset_n,
    .dataslot_requestread,
    .dataslot_requestread_ack,
    .dataslot_update
);

// ==== core_bridge_cmd_tb.sv ====
/*
 * testbench for the bridge command handler with clock, reset, vector file
 * driven bridge and core transactions, slot read responder and checks
 */
module core_bridge_cmd_tb;

    logic        clk;
    logic        rst;
    logic        bridge_endian_little;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic [31:0] bridge_rd_data;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic        status_boot_done;
    logic        status_setup_done;
    logic        status_running;
    logic        reset_n;
    logic        dataslot_requestread;
    logic [15:0] dataslot_requestread_id;
    logic        dataslot_requestread_ack;
    logic        dataslot_requestread_ok;
    logic        dataslot_update;
    logic [15:0] dataslot_update_id;
    logic [31:0] dataslot_update_size;
    logic        dataslot_allcomplete;
    logic        rtc_valid;
    logic [31:0] rtc_epoch_seconds;
    logic [31:0] rtc_date_bcd;
    logic [31:0] rtc_time_bcd;
    logic        osnotify_inmenu;
    logic        osnotify_docked;
    logic [9:0]  datatable_addr;
    logic        datatable_wren;
    logic [31:0] datatable_data;
    logic [31:0] datatable_q;

    int          v_id[$];
    int          v_op[$];
    int          v_endian[$];
    logic [31:0] v_addr[$];
    logic [31:0] v_data[$];
    logic [31:0] v_exp[$];
    int          vec_count = 0;
    int          cur_id = -1;
    int          tests = 0;
    int          failed_tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    // host side view of the commands, used for the core-side levels
    logic [31:0] param0_model = '0;
    logic [15:0] pending_cmd = '0;
    logic        exp_allcomplete = 1'b0;
    logic        exp_inmenu = 1'b0;
    logic        exp_docked = 1'b0;
    int          update_pulses = 0;
    int          exp_update_pulses = 0;

    core_bridge_cmd i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // answers a slot read three cycles after the request shows up
    initial begin
        forever begin
            @(posedge clk);
            if (dataslot_requestread && !dataslot_requestread_ack) begin
                repeat (3) @(posedge clk);
                dataslot_requestread_ack <= 1'b1;
                while (dataslot_requestread) @(posedge clk);
                dataslot_requestread_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (dataslot_update)
            update_pulses++;    // cycles with the strobe high
    end

    initial begin
        wait (vec_count > 0);
        #(vec_count * 200 * 40);
        $display("watchdog expired before the vectors were done");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Error: test %0d %s = %h, expected %h", cur_id, name, got, exp);
        end
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] w;
        w = bridge_endian_little ? {data[7:0], data[15:8], data[23:16], data[31:24]} : data;
        if (addr[31:24] == 8'hF8 && addr[15:0] == 16'h0020)
            param0_model = w;
        if (addr[31:24] == 8'hF8 && addr[15:0] == 16'h0000 && w[31:16] == 16'h434D)
            pending_cmd = w[15:0];
        @(posedge clk);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk);
        bridge_wr      <= 1'b0;
    endtask

    // read data is valid two edges after the sampling edge
    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(posedge clk);
        bridge_rd   <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        data = bridge_rd_data;
    endtask

    // expected core-side levels once a command has finished
    task automatic apply_command(input logic [15:0] code);
        case (code)
            16'h0080: exp_allcomplete = 1'b0;
            16'h008A: exp_update_pulses++;
            16'h008F: exp_allcomplete = 1'b1;
            16'h00B0: exp_inmenu = param0_model[0];
            16'h00B2: exp_docked = param0_model[0];
            default: ;
        endcase
    endtask

    task automatic poll_status(input logic [31:0] exp);
        logic [31:0] word;
        int          tries;
        tries = 0;
        bridge_read(32'hF800_0000, word);
        while (word[31:16] != 16'h4F4B && tries < 50) begin
            bridge_read(32'hF800_0000, word);
            tries++;
        end
        if (word[31:16] != 16'h4F4B) begin
            errors++;
            test_errors++;
            $display("test %0d: status word never showed the ok magic", cur_id);
        end else begin
            check_value("status word", word, exp);
            apply_command(pending_cmd);
            check_value("dataslot_requestread", {31'd0, dataslot_requestread}, 32'd0);
            check_value("dataslot_update pulses", update_pulses, exp_update_pulses);
            check_value("dataslot_allcomplete", {31'd0, dataslot_allcomplete},
                        {31'd0, exp_allcomplete});
            check_value("osnotify_inmenu", {31'd0, osnotify_inmenu}, {31'd0, exp_inmenu});
            check_value("osnotify_docked", {31'd0, osnotify_docked}, {31'd0, exp_docked});
        end
    endtask

    function automatic string output_name(input logic [31:0] sel);
        case (sel)
            0: return "reset_n";
            1: return "rtc_epoch_seconds";
            2: return "rtc_date_bcd";
            3: return "rtc_time_bcd";
            4: return "rtc_valid";
            5: return "dataslot_update_id";
            6: return "dataslot_update_size";
            default: return "dataslot_requestread_id";
        endcase
    endfunction

    function automatic logic [31:0] output_value(input logic [31:0] sel);
        case (sel)
            0: return {31'd0, reset_n};
            1: return rtc_epoch_seconds;
            2: return rtc_date_bcd;
            3: return rtc_time_bcd;
            4: return {31'd0, rtc_valid};
            5: return {16'd0, dataslot_update_id};
            6: return dataslot_update_size;
            default: return {16'd0, dataslot_requestread_id};
        endcase
    endfunction

    task automatic close_test();
        if (cur_id >= 0) begin
            tests++;
            if (test_errors == 0) begin
                $display("test %0d: pass", cur_id);
            end else begin
                failed_tests++;
                $display("test %0d: FAIL with %0d errors", cur_id, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic load_vectors();
        int          fd;
        int          id, op, en;
        logic [31:0] a, d, e;
        string       line;
        fd = $fopen("core_bridge_cmd_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%d %d %d %h %h %h", id, op, en, a, d, e) == 6) begin
                    v_id.push_back(id);
                    v_op.push_back(op);
                    v_endian.push_back(en);
                    v_addr.push_back(a);
                    v_data.push_back(d);
                    v_exp.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic [31:0] got;
        rst = 1'b1;
        bridge_endian_little = 1'b0;
        bridge_addr = '0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        bridge_wr_data = '0;
        status_boot_done = 1'b0;
        status_setup_done = 1'b0;
        status_running = 1'b0;
        dataslot_requestread_ack = 1'b0;
        dataslot_requestread_ok = 1'b0;
        datatable_addr = '0;
        datatable_wren = 1'b0;
        datatable_data = '0;
        load_vectors();
        vec_count = v_id.size();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < vec_count; i++) begin
            if (v_id[i] != cur_id) begin
                close_test();
                cur_id = v_id[i];
            end
            if (v_endian[i][0] != bridge_endian_little) begin
                @(posedge clk);
                bridge_endian_little <= v_endian[i][0];
                repeat (4) @(posedge clk);  // let the flag through the synchronizer
            end
            case (v_op[i])
                0: bridge_write(v_addr[i], v_data[i]);
                1: begin
                    bridge_read(v_addr[i], got);
                    check_value("bridge_rd_data", got, v_exp[i]);
                end
                2: poll_status(v_exp[i]);
                3: begin
                    @(posedge clk);
                    datatable_addr <= v_addr[i][9:0];
                    datatable_data <= v_data[i];
                    datatable_wren <= 1'b1;
                    @(posedge clk);
                    datatable_wren <= 1'b0;
                end
                4: begin
                    @(posedge clk);
                    datatable_addr <= v_addr[i][9:0];
                    repeat (2) @(posedge clk);
                    @(negedge clk);
                    check_value("datatable_q", datatable_q, v_exp[i]);
                end
                5: begin
                    @(posedge clk);
                    status_boot_done        <= v_data[i][0];
                    status_setup_done       <= v_data[i][1];
                    status_running          <= v_data[i][2];
                    dataslot_requestread_ok <= v_data[i][3];
                end
                default: begin
                    @(negedge clk);
                    check_value(output_name(v_addr[i]), output_value(v_addr[i]), v_exp[i]);
                end
            endcase
        end
        close_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== core_bridge_cmd_input.txt ====
# id op endian addr data expected, all but id op endian in hex
# op 0 bridge wr, 1 bridge rd, 2 poll status, 3 core wr, 4 core rd, 5 levels, 6 output
1 5 0 00000000 00000000 00000000
1 0 0 F8000000 434D0000 00000000
1 2 0 F8000000 00000000 4F4B0001
1 5 0 00000000 00000001 00000000
1 0 0 F8000000 434D0000 00000000
1 2 0 F8000000 00000000 4F4B0002
1 5 0 00000000 00000003 00000000
1 0 0 F8000000 434D0000 00000000
1 2 0 F8000000 00000000 4F4B0003
1 5 0 00000000 00000005 00000000
1 0 0 F8000000 434D0000 00000000
1 2 0 F8000000 00000000 4F4B0004
2 0 0 F8000000 434D0011 00000000
2 2 0 F8000000 00000000 4F4B0000
2 6 0 00000000 00000000 00000001
2 0 0 F8000000 434D0010 00000000
2 2 0 F8000000 00000000 4F4B0000
2 6 0 00000000 00000000 00000000
3 0 0 F8000020 5F5E1000 00000000
3 0 0 F8000024 20240115 00000000
3 0 0 F8000028 00123456 00000000
3 0 0 F8000000 434D0090 00000000
3 2 0 F8000000 00000000 4F4B0000
3 6 0 00000001 00000000 5F5E1000
3 6 0 00000002 00000000 20240115
3 6 0 00000003 00000000 00123456
3 6 0 00000004 00000000 00000001
3 0 0 F8000000 434D008A 00000000
3 2 0 F8000000 00000000 4F4B0000
3 6 0 00000005 00000000 00001000
3 6 0 00000006 00000000 20240115
4 0 0 F8000020 0000ABCD 00000000
4 5 0 00000000 00000009 00000000
4 0 0 F8000000 434D0080 00000000
4 2 0 F8000000 00000000 4F4B0000
4 6 0 00000007 00000000 0000ABCD
4 5 0 00000000 00000001 00000000
4 0 0 F8000000 434D0080 00000000
4 2 0 F8000000 00000000 4F4B0002
5 0 0 F8000000 434D0055 00000000
5 2 0 F8000000 00000000 4F4BFFFF
5 1 0 F8000004 00000000 00000020
5 1 0 F8000008 00000000 00000040
6 0 0 F8002010 11223344 00000000
6 4 0 00000004 00000000 11223344
6 3 0 00000007 CAFEF00D 00000000
6 1 0 F800201C 00000000 CAFEF00D
6 0 1 F8002020 11223344 00000000
6 4 1 00000008 00000000 44332211
6 1 1 F800201C 00000000 0DF0FECA

// ==== core_bridge_cmd.f ====
bridge_cmd_pkg.sv
bridge_port.sv
host_regfile.sv
host_cmd_exec.sv
datatable_ram.sv
core_bridge_cmd.sv
core_bridge_cmd_checker.sv
core_bridge_cmd_tb.sv

// ==== Makefile ====
TOP := core_bridge_cmd_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f core_bridge_cmd.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
